//--- src/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

`define EXU_XLEN        32
`define EXU_LINK_STEP   32'd4
`define EXU_SHAMT_W     5
`define EXU_F7_ALT_BIT  5       // bit 30 seen from funct7.
`define EXU_IMM_ALT_BIT 10      // bit 30 seen from the i-type imm.

`define EXU_OP_R        7'b0110011
`define EXU_OP_I        7'b0010011
`define EXU_OP_LOAD     7'b0000011
`define EXU_OP_STORE    7'b0100011
`define EXU_OP_BRANCH   7'b1100011
`define EXU_OP_JAL      7'b1101111
`define EXU_OP_JALR     7'b1100111
`define EXU_OP_LUI      7'b0110111
`define EXU_OP_AUIPC    7'b0010111

`define EXU_F3_ADD      3'b000
`define EXU_F3_SLL      3'b001
`define EXU_F3_SLT      3'b010
`define EXU_F3_SLTU     3'b011
`define EXU_F3_XOR      3'b100
`define EXU_F3_SR       3'b101  // srl or sra.
`define EXU_F3_OR       3'b110
`define EXU_F3_AND      3'b111

`define EXU_F3_LB       3'b000
`define EXU_F3_LH       3'b001
`define EXU_F3_LW       3'b010
`define EXU_F3_LBU      3'b100
`define EXU_F3_LHU      3'b101

`define EXU_F3_SB       3'b000
`define EXU_F3_SH       3'b001
`define EXU_F3_SW       3'b010

`define EXU_F3_BEQ      3'b000
`define EXU_F3_BNE      3'b001
`define EXU_F3_BLT      3'b100
`define EXU_F3_BGE      3'b101
`define EXU_F3_BLTU     3'b110
`define EXU_F3_BGEU     3'b111

`endif

//--- src/exu_pkg.sv
`default_nettype none

package exu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef union packed {
        struct packed {
            logic [6:0]  funct7;
            logic [4:0]  rs2;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } r;
        struct packed {
            logic [11:0] imm;    // funct7 sits in the upper bits for shifts.
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_word_u;

endpackage

`default_nettype wire

//--- src/exu_decode.sv
`include "exu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_decode (
    input  wire  [31:0]         inst_i,
    output exu_pkg::alu_op_e    alu_op_o,
    output logic                use_imm_o,
    output logic                use_pc_o,
    output logic                is_load_o,
    output logic                is_store_o,
    output logic                is_branch_o,
    output logic                is_jal_o,
    output logic                is_jalr_o,
    output logic                is_lui_o,
    output logic                writes_rd_o
);

    exu_pkg::inst_word_u word;

    assign word = inst_i;

    function automatic exu_pkg::alu_op_e alu_from_f3(
        input logic [2:0] f3,
        input logic       alt,
        input logic       sub_ok
    );
        exu_pkg::alu_op_e op;
        case (f3)
            `EXU_F3_ADD:  op = (alt && sub_ok) ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
            `EXU_F3_SLL:  op = exu_pkg::ALU_SLL;
            `EXU_F3_SLT:  op = exu_pkg::ALU_SLT;
            `EXU_F3_SLTU: op = exu_pkg::ALU_SLTU;
            `EXU_F3_XOR:  op = exu_pkg::ALU_XOR;
            `EXU_F3_SR:   op = alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
            `EXU_F3_OR:   op = exu_pkg::ALU_OR;
            `EXU_F3_AND:  op = exu_pkg::ALU_AND;
            default:      op = exu_pkg::ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        alu_op_o    = exu_pkg::ALU_ADD;
        use_imm_o   = 1'b0;
        use_pc_o    = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        is_lui_o    = 1'b0;
        writes_rd_o = 1'b0;

        case (word.r.opcode)
            `EXU_OP_R: begin
                alu_op_o    = alu_from_f3(word.r.funct3, word.r.funct7[`EXU_F7_ALT_BIT], 1'b1);
                writes_rd_o = 1'b1;
            end
            `EXU_OP_I: begin
                // addi never subtracts, only srai looks at bit 30.
                alu_op_o    = alu_from_f3(word.i.funct3, word.i.imm[`EXU_IMM_ALT_BIT], 1'b0);
                writes_rd_o = 1'b1;
            end
            `EXU_OP_LOAD: begin
                use_imm_o   = 1'b1;
                is_load_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            `EXU_OP_STORE: begin
                use_imm_o   = 1'b1;
                is_store_o  = 1'b1;
            end
            `EXU_OP_BRANCH: is_branch_o = 1'b1;
            `EXU_OP_JAL: begin
                is_jal_o    = 1'b1;
                writes_rd_o = 1'b1;
            end
            `EXU_OP_JALR: begin
                use_imm_o   = 1'b1;
                is_jalr_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            `EXU_OP_LUI: begin
                is_lui_o    = 1'b1;
                writes_rd_o = 1'b1;
            end
            `EXU_OP_AUIPC: begin
                use_pc_o    = 1'b1;     // pc plus offset.
                use_imm_o   = 1'b1;
                writes_rd_o = 1'b1;
            end
            default: ;                  // csr and unknown do nothing.
        endcase
    end

endmodule

`default_nettype wire

//--- src/exu_alu.sv
`include "exu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_alu (
    input  wire  [`EXU_XLEN-1:0]    op_a_i,
    input  wire  [`EXU_XLEN-1:0]    op_b_i,
    input  wire  exu_pkg::alu_op_e  alu_op_i,
    output logic [`EXU_XLEN-1:0]    result_o
);

    logic [`EXU_SHAMT_W-1:0] shamt;
    logic                    lt_s;
    logic                    lt_u;

    assign shamt = op_b_i[`EXU_SHAMT_W-1:0];
    assign lt_s  = $signed(op_a_i) < $signed(op_b_i);
    assign lt_u  = op_a_i < op_b_i;

    always_comb begin
        case (alu_op_i)
            exu_pkg::ALU_ADD:  result_o = op_a_i + op_b_i;
            exu_pkg::ALU_SUB:  result_o = op_a_i - op_b_i;
            exu_pkg::ALU_SLL:  result_o = op_a_i << shamt;
            exu_pkg::ALU_SLT:  result_o = {{(`EXU_XLEN-1){1'b0}}, lt_s};
            exu_pkg::ALU_SLTU: result_o = {{(`EXU_XLEN-1){1'b0}}, lt_u};
            exu_pkg::ALU_XOR:  result_o = op_a_i ^ op_b_i;
            exu_pkg::ALU_SRL:  result_o = op_a_i >> shamt;
            exu_pkg::ALU_SRA:  result_o = $signed(op_a_i) >>> shamt;   // keeps the sign.
            exu_pkg::ALU_OR:   result_o = op_a_i | op_b_i;
            exu_pkg::ALU_AND:  result_o = op_a_i & op_b_i;
            default:           result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/exu_lsu_align.sv
`include "exu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_lsu_align (
    input  wire  [2:0]              funct3_i,
    input  wire  [1:0]              addr_lo_i,
    input  wire  [`EXU_XLEN-1:0]    rdata_i,
    input  wire  [`EXU_XLEN-1:0]    store_data_i,
    output logic [`EXU_XLEN-1:0]    load_data_o,
    output logic [`EXU_XLEN-1:0]    store_word_o
);

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // lanes picked straight from the address.
    assign byte_lane = rdata_i[{addr_lo_i, 3'b000} +: 8];
    assign half_lane = addr_lo_i[1] ? rdata_i[31:16] : rdata_i[15:0];

    always_comb begin
        case (funct3_i)
            `EXU_F3_LB:  load_data_o = {{(`EXU_XLEN-8){byte_lane[7]}}, byte_lane};
            `EXU_F3_LH:  load_data_o = {{(`EXU_XLEN-16){half_lane[15]}}, half_lane};
            `EXU_F3_LW:  load_data_o = rdata_i;
            `EXU_F3_LBU: load_data_o = {{(`EXU_XLEN-8){1'b0}}, byte_lane};
            `EXU_F3_LHU: load_data_o = {{(`EXU_XLEN-16){1'b0}}, half_lane};
            default:     load_data_o = '0;
        endcase
    end

    // read-modify-write against the word just read.
    always_comb begin
        store_word_o = rdata_i;
        case (funct3_i)
            `EXU_F3_SB: store_word_o[{addr_lo_i, 3'b000} +: 8] = store_data_i[7:0];
            `EXU_F3_SH: store_word_o[{addr_lo_i[1], 4'b0000} +: 16] = store_data_i[15:0];
            `EXU_F3_SW: store_word_o = store_data_i;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- src/exu_branch.sv
`include "exu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_branch (
    input  wire  [2:0]              funct3_i,
    input  wire  [`EXU_XLEN-1:0]    op1_i,
    input  wire  [`EXU_XLEN-1:0]    op2_i,
    input  wire  [`EXU_XLEN-1:0]    pc_i,
    input  wire  [`EXU_XLEN-1:0]    offset_i,
    input  wire                     is_branch_i,
    input  wire                     is_jal_i,
    input  wire                     is_jalr_i,
    output logic                    taken_o,
    output logic [`EXU_XLEN-1:0]    target_o,
    output logic [`EXU_XLEN-1:0]    link_o
);

    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;
    logic                 cond;
    logic [`EXU_XLEN-1:0] jalr_sum;

    assign eq       = op1_i == op2_i;
    assign lt_s     = $signed(op1_i) < $signed(op2_i);
    assign lt_u     = op1_i < op2_i;
    assign jalr_sum = op1_i + offset_i;

    always_comb begin
        case (funct3_i)
            `EXU_F3_BEQ:  cond = eq;
            `EXU_F3_BNE:  cond = !eq;
            `EXU_F3_BLT:  cond = lt_s;
            `EXU_F3_BGE:  cond = !lt_s;
            `EXU_F3_BLTU: cond = lt_u;
            `EXU_F3_BGEU: cond = !lt_u;
            default:      cond = 1'b0;
        endcase
    end

    assign taken_o  = (is_branch_i && cond) || is_jal_i || is_jalr_i;
    assign target_o = is_jalr_i ? {jalr_sum[`EXU_XLEN-1:1], 1'b0} : pc_i + offset_i;
    assign link_o   = pc_i + `EXU_LINK_STEP;   // return address.

endmodule

`default_nettype wire

//--- src/exu_top.sv
`include "exu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module exu_top (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire  [31:0]             inst_i,
    input  wire  [`EXU_XLEN-1:0]    inst_addr_i,
    input  wire  [`EXU_XLEN-1:0]    op1_i,
    input  wire  [`EXU_XLEN-1:0]    op2_i,
    input  wire  [`EXU_XLEN-1:0]    offset_i,
    input  wire                     reg_wen_i,
    input  wire  [4:0]              reg_waddr_i,
    input  wire  [`EXU_XLEN-1:0]    mem_rdata_i,
    output logic [`EXU_XLEN-1:0]    mem_raddr_o,
    output logic                    reg_wen_o,
    output logic [4:0]              reg_waddr_o,
    output logic [`EXU_XLEN-1:0]    reg_wdata_o,
    output logic                    mem_wen_o,
    output logic [`EXU_XLEN-1:0]    mem_waddr_o,
    output logic [`EXU_XLEN-1:0]    mem_wdata_o,
    output logic                    jump_flag_o,
    output logic [`EXU_XLEN-1:0]    jump_addr_o
);

    exu_pkg::inst_word_u  word;
    exu_pkg::alu_op_e     alu_op;
    logic                 use_imm, use_pc, writes_rd;
    logic                 is_load, is_store, is_branch, is_jal, is_jalr, is_lui;
    logic                 taken;
    logic [`EXU_XLEN-1:0] op_a, op_b, alu_result;
    logic [`EXU_XLEN-1:0] load_data, store_word, target, link, wb_data;

    assign word = inst_i;

    exu_decode u_decode (
        .inst_i      (inst_i),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .use_pc_o    (use_pc),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_lui_o    (is_lui),
        .writes_rd_o (writes_rd)
    );

    assign op_a = use_pc ? inst_addr_i : op1_i;
    assign op_b = use_imm ? offset_i : op2_i;

    exu_alu u_alu (
        .op_a_i   (op_a),
        .op_b_i   (op_b),
        .alu_op_i (alu_op),
        .result_o (alu_result)
    );

    assign mem_raddr_o = (is_load || is_store) ? alu_result : '0;

    exu_lsu_align u_lsu_align (
        .funct3_i     (word.r.funct3),
        .addr_lo_i    (mem_raddr_o[1:0]),
        .rdata_i      (mem_rdata_i),
        .store_data_i (op2_i),
        .load_data_o  (load_data),
        .store_word_o (store_word)
    );

    exu_branch u_branch (
        .funct3_i    (word.r.funct3),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .pc_i        (inst_addr_i),
        .offset_i    (offset_i),
        .is_branch_i (is_branch),
        .is_jal_i    (is_jal),
        .is_jalr_i   (is_jalr),
        .taken_o     (taken),
        .target_o    (target),
        .link_o      (link)
    );

    always_comb begin
        if (is_load) begin
            wb_data = load_data;
        end else if (is_jal || is_jalr) begin
            wb_data = link;
        end else if (is_lui) begin
            wb_data = op1_i;            // upper immediate arrives on op1.
        end else begin
            wb_data = alu_result;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_wen_o   <= 1'b0;
            reg_waddr_o <= '0;
            reg_wdata_o <= '0;
            mem_wen_o   <= 1'b0;
            mem_waddr_o <= '0;
            mem_wdata_o <= '0;
            jump_flag_o <= 1'b0;
            jump_addr_o <= '0;
        end else begin
            reg_wen_o   <= reg_wen_i && writes_rd;
            reg_waddr_o <= reg_waddr_i;
            reg_wdata_o <= wb_data;
            mem_wen_o   <= is_store;
            mem_waddr_o <= mem_raddr_o;
            mem_wdata_o <= store_word;
            jump_flag_o <= taken;
            jump_addr_o <= taken ? target : '0;     // zero when not redirecting.
        end
    end

    a_store_no_jump: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_wen_o && jump_flag_o))
        else $error("store and jump issued together");

    a_alu_op_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(alu_op))
        else $error("decoded alu op is unknown");

    // Halfwords on even bytes, words on word boundaries.
    a_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (is_load || is_store) |->
            (!(word.r.funct3 inside {`EXU_F3_LH, `EXU_F3_LHU}) || !mem_raddr_o[0]) &&
            (word.r.funct3 != `EXU_F3_LW || mem_raddr_o[1:0] == 2'b00))
        else $error("misaligned memory access");

endmodule

`default_nettype wire

//--- verification/tb_exu.sv
`include "exu_consts.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_exu;

    localparam int DRAIN_LIMIT = 8;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] inst_i;
    logic [31:0] inst_addr_i;
    logic [31:0] op1_i;
    logic [31:0] op2_i;
    logic [31:0] offset_i;
    logic        reg_wen_i;
    logic [4:0]  reg_waddr_i;
    logic [31:0] mem_rdata_i;
    logic [31:0] mem_raddr_o;
    logic        reg_wen_o;
    logic [4:0]  reg_waddr_o;
    logic [31:0] reg_wdata_o;
    logic        mem_wen_o;
    logic [31:0] mem_waddr_o;
    logic [31:0] mem_wdata_o;
    logic        jump_flag_o;
    logic [31:0] jump_addr_o;

    logic [31:0] mem [0:63];
    logic [31:0] issued;
    logic [31:0] landed = '0;
    logic [31:0] retired = '0;
    int          errors;
    int          n_inst;
    int          tests_run;
    int          failed_tests;
    logic        timed_out;

    // expected results for the instruction on the inputs.
    logic        exp_rd;
    logic        exp_wen;
    logic [31:0] exp_wdata;
    logic        exp_mem_wen;
    logic [31:0] exp_maddr;
    logic [31:0] exp_mdata;
    logic [31:0] exp_raddr;
    logic        exp_jump;
    logic [31:0] exp_jaddr;
    logic        exp_jalr;
    logic [31:0] ea;

    exu_top u_exu_top (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .offset_i    (offset_i),
        .reg_wen_i   (reg_wen_i),
        .reg_waddr_i (reg_waddr_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_raddr_o (mem_raddr_o),
        .reg_wen_o   (reg_wen_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .mem_wen_o   (mem_wen_o),
        .mem_waddr_o (mem_waddr_o),
        .mem_wdata_o (mem_wdata_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    always #10 clk_i = ~clk_i;

    assign mem_rdata_i = mem[mem_raddr_o[7:2]];     // combinational read.

    always @(posedge clk_i) begin
        if (mem_wen_o) begin
            mem[mem_waddr_o[7:2]] <= mem_wdata_o;
        end
    end

    // results land one edge after issue and are checked on the next.
    always @(posedge clk_i) begin
        landed  <= issued;
        retired <= landed;
    end

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] r;
        sh = b[4:0];
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << sh;
            3'b010: r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $unsigned($signed(a) >>> sh);
                end else begin
                    r = a >> sh;
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [1:0] lane,
                                             input logic [31:0] w);
        logic [31:0] s;
        s = w >> {lane, 3'b000};
        case (f3)
            `EXU_F3_LB:  return {{24{s[7]}}, s[7:0]};
            `EXU_F3_LH:  return {{16{s[15]}}, s[15:0]};
            `EXU_F3_LW:  return w;
            `EXU_F3_LBU: return {24'h0, s[7:0]};
            `EXU_F3_LHU: return {16'h0, s[15:0]};
            default:     return 32'h0;
        endcase
    endfunction

    function automatic logic [31:0] merge_ref(input logic [2:0] f3, input logic [1:0] lane,
                                              input logic [31:0] w, input logic [31:0] d);
        logic [31:0] mask;
        case (f3)
            `EXU_F3_SB: mask = 32'h0000_00ff << {lane, 3'b000};
            `EXU_F3_SH: mask = 32'h0000_ffff << {lane, 3'b000};
            default:    mask = 32'hffff_ffff;
        endcase
        return (w & ~mask) | ((d << {lane, 3'b000}) & mask);
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            `EXU_F3_BEQ:  return a == b;
            `EXU_F3_BNE:  return a != b;
            `EXU_F3_BLT:  return $signed(a) < $signed(b);
            `EXU_F3_BGE:  return $signed(a) >= $signed(b);
            `EXU_F3_BLTU: return a < b;
            `EXU_F3_BGEU: return a >= b;
            default:      return 1'b0;
        endcase
    endfunction

    function automatic logic lane_aligned(input logic [2:0] f3, input logic [1:0] lane);
        case (f3[1:0])
            2'b01:   return !lane[0];
            2'b10:   return lane == 2'b00;
            default: return 1'b1;
        endcase
    endfunction

    function automatic logic supported(input logic [6:0] opc);
        return opc inside {`EXU_OP_R, `EXU_OP_I, `EXU_OP_LOAD, `EXU_OP_STORE, `EXU_OP_BRANCH,
                           `EXU_OP_JAL, `EXU_OP_JALR, `EXU_OP_LUI, `EXU_OP_AUIPC};
    endfunction

    always_comb begin
        ea          = op1_i + offset_i;
        exp_rd      = 1'b0;
        exp_wdata   = 32'h0;
        exp_mem_wen = 1'b0;
        exp_maddr   = 32'h0;
        exp_mdata   = 32'h0;
        exp_raddr   = 32'h0;
        exp_jump    = 1'b0;
        exp_jaddr   = 32'h0;
        exp_jalr    = 1'b0;
        case (inst_i[6:0])
            `EXU_OP_R: begin
                exp_rd    = 1'b1;
                exp_wdata = alu_ref(inst_i[14:12], inst_i[30], op1_i, op2_i);
            end
            `EXU_OP_I: begin
                exp_rd    = 1'b1;
                exp_wdata = alu_ref(inst_i[14:12], inst_i[30] && inst_i[14:12] == 3'b101,
                                    op1_i, op2_i);
            end
            `EXU_OP_LOAD: begin
                exp_raddr = ea;
                exp_rd    = 1'b1;
                exp_wdata = load_ref(inst_i[14:12], ea[1:0], mem_rdata_i);
            end
            `EXU_OP_STORE: begin
                exp_raddr   = ea;
                exp_mem_wen = 1'b1;
                exp_maddr   = ea;
                exp_mdata   = merge_ref(inst_i[14:12], ea[1:0], mem_rdata_i, op2_i);
            end
            `EXU_OP_BRANCH: begin
                exp_jump  = branch_ref(inst_i[14:12], op1_i, op2_i);
                exp_jaddr = inst_addr_i + offset_i;
            end
            `EXU_OP_JAL: begin
                exp_rd    = 1'b1;
                exp_wdata = inst_addr_i + 32'd4;
                exp_jump  = 1'b1;
                exp_jaddr = inst_addr_i + offset_i;
            end
            `EXU_OP_JALR: begin
                exp_rd    = 1'b1;
                exp_wdata = inst_addr_i + 32'd4;
                exp_jump  = 1'b1;
                exp_jaddr = ea & ~32'd1;
                exp_jalr  = 1'b1;
            end
            `EXU_OP_LUI: begin
                exp_rd    = 1'b1;
                exp_wdata = op1_i;
            end
            `EXU_OP_AUIPC: begin
                exp_rd    = 1'b1;
                exp_wdata = inst_addr_i + offset_i;
            end
            default: ;
        endcase
        exp_wen = reg_wen_i && exp_rd;
    end

    task automatic report_mismatch(input string what);
        errors++;
        $display("error at %0t ns: %s", $time, what);
    endtask

    a_raddr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_raddr_o == exp_raddr)
        else report_mismatch("mem_raddr_o differs from the reference model");
    a_wen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_wen_o == $past(exp_wen))
        else report_mismatch("reg_wen_o differs from the reference model");
    a_waddr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_waddr_o == $past(reg_waddr_i))
        else report_mismatch("reg_waddr_o differs from reg_waddr_i");
    a_wdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(exp_rd) |-> reg_wdata_o == $past(exp_wdata))
        else report_mismatch("reg_wdata_o differs from the reference model");
    a_mem_wen: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_wen_o == $past(exp_mem_wen))
        else report_mismatch("mem_wen_o differs from the reference model");
    a_mem_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(exp_mem_wen) |-> mem_waddr_o == $past(exp_maddr))
        else report_mismatch("mem_waddr_o differs from op1 plus offset");
    a_mem_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(exp_mem_wen) |-> mem_wdata_o == $past(exp_mdata))
        else report_mismatch("mem_wdata_o differs from the merged word");
    a_jump: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        jump_flag_o == $past(exp_jump))
        else report_mismatch("jump_flag_o differs from the reference model");
    a_jump_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(exp_jump) |-> jump_addr_o == $past(exp_jaddr))
        else report_mismatch("jump_addr_o differs from the reference model");
    a_jalr_even: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(exp_jalr) |-> !jump_addr_o[0])
        else report_mismatch("jalr target has bit 0 set");
    // outputs quiet on the first edge out of reset.
    a_reset_quiet: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !reg_wen_o && !mem_wen_o && !jump_flag_o)
        else report_mismatch("outputs active right after reset");

    task automatic issue(input logic [31:0] inst, input logic [31:0] pc, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] off, input logic wen);
        @(posedge clk_i);
        inst_i      <= inst;
        inst_addr_i <= pc;
        op1_i       <= a;
        op2_i       <= b;
        offset_i    <= off;
        reg_wen_i   <= wen;
        reg_waddr_i <= inst[11:7];
        issued      <= issued + 1;
        n_inst++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk_i);
        inst_i    <= 32'h0;             // bubble.
        reg_wen_i <= 1'b0;
        @(negedge clk_i);
        while (retired != issued && waited < DRAIN_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
        if (retired != issued) begin
            timed_out = 1'b1;
            $display("timeout: results still pending after %0d cycles", DRAIN_LIMIT);
        end
    endtask

    task automatic alu_ops();
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 160; i++) begin
            f3  = 3'(i % 8);
            alt = ((i / 8) % 2) == 1;
            a   = $urandom;
            if (i < 80) begin
                b = (i % 7 == 0) ? a : $urandom;
                issue({1'b0, alt, 5'b0, 5'($urandom), 5'($urandom), f3, 5'($urandom), `EXU_OP_R},
                      $urandom, a, b, $urandom, 1'($urandom));
            end else begin
                imm     = 12'($urandom);
                imm[10] = alt;          // addi with bit 30 set must still add.
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm[11]  = 1'b0;
                    imm[9:5] = 5'b0;
                end
                b = {{20{imm[11]}}, imm};
                issue({imm, 5'($urandom), f3, 5'($urandom), `EXU_OP_I},
                      $urandom, a, b, $urandom, 1'($urandom));
            end
        end
    endtask

    task automatic load_lanes();
        logic [2:0]  f3;
        logic [31:0] base;
        for (int k = 0; k < 5; k++) begin
            case (k)
                0: f3 = `EXU_F3_LB;
                1: f3 = `EXU_F3_LH;
                2: f3 = `EXU_F3_LW;
                3: f3 = `EXU_F3_LBU;
                default: f3 = `EXU_F3_LHU;
            endcase
            for (int l = 0; l < 4; l++) begin
                for (int r = 0; r < 3 && lane_aligned(f3, 2'(l)); r++) begin
                    base = 32'($urandom % 60) << 2;
                    issue({12'(16 + l), 5'($urandom), f3, 5'($urandom), `EXU_OP_LOAD},
                          $urandom, base, $urandom, 32'(16 + l), 1'b1);
                end
            end
        end
    endtask

    task automatic store_merges();
        logic [2:0]  f3;
        logic [31:0] base;
        for (int k = 0; k < 3; k++) begin
            f3 = 3'(k);                 // sb, sh, sw.
            for (int l = 0; l < 4; l++) begin
                for (int r = 0; r < 3 && lane_aligned(f3, 2'(l)); r++) begin
                    base = 32'($urandom % 60) << 2;
                    issue({7'd0, 5'($urandom), 5'($urandom), f3, 5'(16 + l), `EXU_OP_STORE},
                          $urandom, base, $urandom, 32'(16 + l), 1'b1);
                end
            end
        end
    endtask

    task automatic branch_conds();
        logic [2:0]  f3;
        logic [12:0] o13;
        logic [31:0] a;
        logic [31:0] b;
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? 3'(k) : 3'(k + 2);
            for (int p = 0; p < 6; p++) begin
                a = $urandom >> 2;
                case (p)
                    0: b = a;
                    1: b = a + ($urandom >> 2) + 32'd1;
                    2: b = a - ($urandom % (a + 32'd1)) - 32'd1;
                    3: begin            // negative against positive.
                        a = $urandom | 32'h8000_0000;
                        b = $urandom >> 1;
                    end
                    4: begin
                        b = $urandom | 32'h8000_0000;
                    end
                    default: b = $urandom;
                endcase
                o13 = 13'($urandom);
                issue({7'($urandom), 5'($urandom), 5'($urandom), f3, 5'($urandom), `EXU_OP_BRANCH},
                      $urandom & 32'hffff_fffc, a, b, {{19{o13[12]}}, o13[12:1], 1'b0}, 1'b1);
            end
        end
    endtask

    task automatic jumps_and_upper();
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] off;
        for (int i = 0; i < 24; i++) begin
            pc  = $urandom & 32'hffff_fffc;
            a   = $urandom;
            off = $urandom;
            case (i % 4)
                0: issue({20'($urandom), 5'($urandom), `EXU_OP_JAL},
                         pc, a, $urandom, {off[31:1], 1'b0}, 1'b1);
                1: issue({12'($urandom), 5'($urandom), 3'b000, 5'($urandom), `EXU_OP_JALR},
                         pc, a, $urandom, off, 1'b1);
                2: issue({20'($urandom), 5'($urandom), `EXU_OP_LUI},
                         pc, {a[31:12], 12'h0}, $urandom, off, 1'b1);
                default: issue({off[31:12], 5'($urandom), `EXU_OP_AUIPC},
                               pc, a, $urandom, {off[31:12], 12'h0}, 1'b1);
            endcase
        end
    endtask

    task automatic unsupported_ops();
        logic [6:0] opc;
        for (int i = 0; i < 24; i++) begin
            opc = 7'($urandom);
            if (i < 6 || supported(opc)) begin
                opc = 7'b1110011;       // system, csr.
            end
            issue({25'($urandom), opc}, $urandom, $urandom, $urandom, $urandom, 1'b1);
        end
    endtask

    task automatic run_test(input int t);
        int    errs_before;
        string name;
        errs_before = errors;
        n_inst      = 0;
        case (t)
            0: name = "reset";
            1: begin
                name = "alu";
                alu_ops();
            end
            2: begin
                name = "loads";
                load_lanes();
            end
            3: begin
                name = "stores";
                store_merges();
            end
            4: begin
                name = "branches";
                branch_conds();
            end
            5: begin
                name = "jumps_upper";
                jumps_and_upper();
            end
            default: begin
                name = "unsupported";
                unsupported_ops();
            end
        endcase
        drain();
        tests_run++;
        if (errors != errs_before || timed_out) begin
            failed_tests++;
        end
        $display("test %0s finished: %0d instructions, %0d errors", name, n_inst,
                 errors - errs_before);
    endtask

    initial begin
        void'($urandom(32'h25ba15bf));
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        inst_i       = 32'h0;
        inst_addr_i  = 32'h0;
        op1_i        = 32'h0;
        op2_i        = 32'h0;
        offset_i     = 32'h0;
        reg_wen_i    = 1'b0;
        reg_waddr_i  = 5'h0;
        issued       = 32'h0;
        errors       = 0;
        n_inst       = 0;
        tests_run    = 0;
        failed_tests = 0;
        timed_out    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = (32'(i) * 32'h0103_0507) ^ 32'h9e37_79b9;
        end
        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int t = 0; t < 7 && !timed_out; t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, failed_tests, errors);
        if (timed_out || failed_tests != 0 || errors != 0) begin
            $display("SOME TESTS FAILED");
        end else begin
            $display("ALL TESTS PASSED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+src
src/exu_pkg.sv
src/exu_decode.sv
src/exu_alu.sv
src/exu_lsu_align.sv
src/exu_branch.sv
src/exu_top.sv
verification/tb_exu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
